/* source/mapper_pkg.sv */
`default_nettype none

package mapper_pkg;

	localparam int NUM_BANKS = 16;

	// field widths of the address scheme
	localparam int ADDR_W = 30;
	localparam int DATA_W = 32;
	localparam int BG_W = 2;
	localparam int BANK_W = 2;
	localparam int ROW_W = 16;
	localparam int COL_W = 10;
	localparam int TAG_W = 6;

	typedef logic [ADDR_W-1:0] addr_t;  // host word address
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [BG_W-1:0] bank_group_t;
	typedef logic [BANK_W-1:0] bank_t;
	typedef logic [ROW_W-1:0] row_t;
	typedef logic [COL_W-1:0] col_t;

	// bank group above bank selects one of 16
	typedef logic [BG_W+BANK_W-1:0] bank_idx_t;
	typedef logic [NUM_BANKS-1:0] bank_sel_t;

	typedef logic [TAG_W-1:0] tag_t;  // up to 64 entries per table

	typedef struct packed {
		bank_group_t bank_group;
		bank_t bank;
		row_t row;
		col_t column;
	} mapped_addr_t;

endpackage

`default_nettype wire

/* source/req_if.sv */
`default_nettype none
`timescale 1ns/1ps

// one mapped request between two pipeline stages
interface req_if;

	logic valid;
	logic ready;
	logic is_write;
	mapper_pkg::mapped_addr_t addr;
	mapper_pkg::data_t data;
	mapper_pkg::tag_t tag;  // only meaningful after allocation

	modport source (
		output valid,
		output is_write,
		output addr,
		output data,
		output tag,
		input ready
	);

	modport sink (
		input valid,
		input is_write,
		input addr,
		input data,
		input tag,
		output ready
	);

endinterface

`default_nettype wire

/* source/addr_mapper.sv */
`default_nettype none
`timescale 1ns/1ps

module addr_mapper (
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire logic req_write,
	input wire mapper_pkg::addr_t req_addr,
	input wire mapper_pkg::data_t req_data,
	output logic req_ready,
	req_if.source out
);

	mapper_pkg::mapped_addr_t mapped;
	logic live;  // low through reset so the host waits
	logic accept;

	// fixed scheme
	always_comb begin
		mapped.bank_group = req_addr[5:4];
		mapped.bank = req_addr[13:12];
		mapped.row = req_addr[29:14];
		mapped.column = {req_addr[11:6], req_addr[3:0]};
	end

	assign req_ready = live && (!out.valid || out.ready);
	assign accept = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			live <= 1'b0;
			out.valid <= 1'b0;
		end else begin
			live <= 1'b1;
			if (accept) begin
				out.valid <= 1'b1;
			end else if (out.ready) begin
				out.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out.addr <= mapped;
			out.is_write <= req_write;
			out.data <= req_data;
		end
	end

	assign out.tag = '0;  // no tag before allocation

endmodule

`default_nettype wire

/* source/entry_table.sv */
`default_nettype none
`timescale 1ns/1ps

module entry_table #(
	parameter int READ_ENTRIES = 8,
	parameter int WRITE_ENTRIES = 8
) (
	input wire logic clk,
	input wire logic rst,
	req_if.sink in,
	req_if.source out,
	input wire logic ret_valid,
	input wire logic ret_write,
	input wire mapper_pkg::tag_t ret_tag
);

	localparam int RD_IW = (READ_ENTRIES > 1) ? $clog2(READ_ENTRIES) : 1;
	localparam int WR_IW = (WRITE_ENTRIES > 1) ? $clog2(WRITE_ENTRIES) : 1;
	localparam int MAX_ENTRIES = 2 ** mapper_pkg::TAG_W;

	logic [READ_ENTRIES-1:0] rd_busy;
	logic [WRITE_ENTRIES-1:0] wr_busy;
	logic [MAX_ENTRIES-1:0] rd_pad;
	logic [MAX_ENTRIES-1:0] wr_pad;
	mapper_pkg::mapped_addr_t wr_addr [WRITE_ENTRIES];
	mapper_pkg::data_t wr_data [WRITE_ENTRIES];
	mapper_pkg::mapped_addr_t rd_addr_q;
	mapper_pkg::tag_t rd_idx;
	mapper_pkg::tag_t wr_idx;
	mapper_pkg::tag_t new_tag;
	logic room;
	logic accept;

	// priority search where the lowest index wins
	function automatic mapper_pkg::tag_t lowest_free(input logic [MAX_ENTRIES-1:0] busy);
		mapper_pkg::tag_t idx;
		idx = '0;
		for (int i = MAX_ENTRIES - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				idx = mapper_pkg::tag_t'(i);
			end
		end
		return idx;
	endfunction

	always_comb begin
		rd_pad = '1;  // slots past the table never look free
		rd_pad[READ_ENTRIES-1:0] = rd_busy;
		wr_pad = '1;
		wr_pad[WRITE_ENTRIES-1:0] = wr_busy;
	end

	assign rd_idx = lowest_free(rd_pad);
	assign wr_idx = lowest_free(wr_pad);
	assign new_tag = in.is_write ? wr_idx : rd_idx;

	// busy bits are registered, so a retire helps only from the next cycle
	assign room = in.is_write ? !(&wr_busy) : !(&rd_busy);
	assign in.ready = room && (!out.valid || out.ready);
	assign accept = in.valid && in.ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_busy <= '0;
			wr_busy <= '0;
			out.valid <= 1'b0;
		end else begin
			if (ret_valid && !ret_write) begin
				rd_busy[ret_tag[RD_IW-1:0]] <= 1'b0;
			end
			if (ret_valid && ret_write) begin
				wr_busy[ret_tag[WR_IW-1:0]] <= 1'b0;
			end
			if (accept && !in.is_write) begin
				rd_busy[rd_idx[RD_IW-1:0]] <= 1'b1;
			end
			if (accept && in.is_write) begin
				wr_busy[wr_idx[WR_IW-1:0]] <= 1'b1;
			end
			if (accept) begin
				out.valid <= 1'b1;
			end else if (out.ready) begin
				out.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out.is_write <= in.is_write;
			out.tag <= new_tag;
			if (in.is_write) begin
				wr_addr[wr_idx[WR_IW-1:0]] <= in.addr;
				wr_data[wr_idx[WR_IW-1:0]] <= in.data;
			end else begin
				rd_addr_q <= in.addr;
			end
		end
	end

	// write payload is read back out of its entry
	assign out.addr = out.is_write ? wr_addr[out.tag[WR_IW-1:0]] : rd_addr_q;
	assign out.data = out.is_write ? wr_data[out.tag[WR_IW-1:0]] : '0;

	a_ret_busy: assert property (@(posedge clk) disable iff (rst)
		ret_valid |-> (ret_write ? wr_busy[ret_tag[WR_IW-1:0]] : rd_busy[ret_tag[RD_IW-1:0]]));

	a_ret_range: assert property (@(posedge clk) disable iff (rst)
		ret_valid |-> int'(ret_tag) < (ret_write ? WRITE_ENTRIES : READ_ENTRIES));

endmodule

`default_nettype wire

/* source/bank_dispatch.sv */
`default_nettype none
`timescale 1ns/1ps

module bank_dispatch (
	input wire logic clk,
	input wire logic rst,
	req_if.sink in,
	output logic disp_valid,
	input wire logic disp_ready,
	output logic disp_write,
	output mapper_pkg::bank_sel_t disp_bank_sel,
	output mapper_pkg::row_t disp_row,
	output mapper_pkg::col_t disp_col,
	output mapper_pkg::data_t disp_data,
	output mapper_pkg::tag_t disp_tag
);

	// two-entry queue
	logic q_write [2];
	mapper_pkg::mapped_addr_t q_addr [2];
	mapper_pkg::data_t q_data [2];
	mapper_pkg::tag_t q_tag [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;
	logic push;
	logic pop;
	mapper_pkg::bank_idx_t head_bank;

	assign in.ready = (count != 2'd2);
	assign push = in.valid && in.ready;
	assign disp_valid = (count != 2'd0);
	assign pop = disp_valid && disp_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= !wr_ptr;
			end
			if (pop) begin
				rd_ptr <= !rd_ptr;
			end
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_write[wr_ptr] <= in.is_write;
			q_addr[wr_ptr] <= in.addr;
			q_data[wr_ptr] <= in.data;
			q_tag[wr_ptr] <= in.tag;
		end
	end

	assign disp_write = q_write[rd_ptr];
	assign disp_row = q_addr[rd_ptr].row;
	assign disp_col = q_addr[rd_ptr].column;
	assign disp_data = q_data[rd_ptr];
	assign disp_tag = q_tag[rd_ptr];
	assign head_bank = {q_addr[rd_ptr].bank_group, q_addr[rd_ptr].bank};

	always_comb begin
		for (int i = 0; i < mapper_pkg::NUM_BANKS; i++) begin
			disp_bank_sel[i] = (head_bank == mapper_pkg::bank_idx_t'(i));
		end
	end

	// scheduler sees a steady request until it takes it
	a_hold: assert property (@(posedge clk) disable iff (rst)
		disp_valid && !disp_ready |=> disp_valid && $stable({disp_write, disp_bank_sel,
			disp_row, disp_col, disp_data, disp_tag}));

endmodule

`default_nettype wire

/* source/mapper_top.sv */
`default_nettype none
`timescale 1ns/1ps

module mapper_top #(
	parameter int READ_ENTRIES = 8,
	parameter int WRITE_ENTRIES = 8
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	output logic req_ready,
	input wire logic req_write,
	input wire mapper_pkg::addr_t req_addr,
	input wire mapper_pkg::data_t req_data,
	output logic disp_valid,
	input wire logic disp_ready,
	output logic disp_write,
	output mapper_pkg::bank_sel_t disp_bank_sel,
	output mapper_pkg::row_t disp_row,
	output mapper_pkg::col_t disp_col,
	output mapper_pkg::data_t disp_data,
	output mapper_pkg::tag_t disp_tag,
	input wire logic ret_valid,
	input wire logic ret_write,
	input wire mapper_pkg::tag_t ret_tag
);

	req_if s1_if ();  // mapper to tables
	req_if s2_if ();  // tables to dispatch

	addr_mapper u_mapper (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_data(req_data),
		.req_ready(req_ready),
		.out(s1_if.source)
	);

	entry_table #(
		.READ_ENTRIES(READ_ENTRIES),
		.WRITE_ENTRIES(WRITE_ENTRIES)
	) u_table (
		.clk(clk),
		.rst(rst),
		.in(s1_if.sink),
		.out(s2_if.source),
		.ret_valid(ret_valid),
		.ret_write(ret_write),
		.ret_tag(ret_tag)
	);

	bank_dispatch u_dispatch (
		.clk(clk),
		.rst(rst),
		.in(s2_if.sink),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp_write(disp_write),
		.disp_bank_sel(disp_bank_sel),
		.disp_row(disp_row),
		.disp_col(disp_col),
		.disp_data(disp_data),
		.disp_tag(disp_tag)
	);

endmodule

`default_nettype wire

/* bench/mapper_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module mapper_tb;

	localparam int ENTRIES = 8;
	localparam int NUM_TESTS = 5;
	localparam int NUM_REQS = 51;  // requests sent over all tests
	localparam int WATCHDOG_NS = NUM_TESTS * 2000 + NUM_REQS * 800;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	logic req_write;
	mapper_pkg::addr_t req_addr;
	mapper_pkg::data_t req_data;
	logic disp_valid;
	logic disp_ready;
	logic disp_write;
	mapper_pkg::bank_sel_t disp_bank_sel;
	mapper_pkg::row_t disp_row;
	mapper_pkg::col_t disp_col;
	mapper_pkg::data_t disp_data;
	mapper_pkg::tag_t disp_tag;
	logic ret_valid;
	logic ret_write;
	mapper_pkg::tag_t ret_tag;

	logic [31:0] lfsr;
	logic [ENTRIES-1:0] rd_model;  // busy bits as the tables should hold them
	logic [ENTRIES-1:0] wr_model;

	mapper_top u_dut (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_data(req_data),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp_write(disp_write),
		.disp_bank_sel(disp_bank_sel),
		.disp_row(disp_row),
		.disp_col(disp_col),
		.disp_data(disp_data),
		.disp_tag(disp_tag),
		.ret_valid(ret_valid),
		.ret_write(ret_write),
		.ret_tag(ret_tag)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
		abort_run();
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_bank_sel(input string name, input mapper_pkg::bank_sel_t exp,
			input mapper_pkg::bank_sel_t got);
		if (got !== exp) begin
			$display("Fail %0t %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_row(input string name, input mapper_pkg::row_t exp,
			input mapper_pkg::row_t got);
		if (got !== exp) begin
			$display("Fail %0t %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_col(input string name, input mapper_pkg::col_t exp,
			input mapper_pkg::col_t got);
		if (got !== exp) begin
			$display("Fail %0t %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input mapper_pkg::data_t exp,
			input mapper_pkg::data_t got);
		if (got !== exp) begin
			$display("Fail %0t %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_tag(input string name, input mapper_pkg::tag_t exp,
			input mapper_pkg::tag_t got);
		if (got !== exp) begin
			$display("Fail %0t %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("Fail %0t %s expected %b got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	// fibonacci lfsr with taps 32 22 2 1
	task automatic draw_bits(input int n, output logic [31:0] val);
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
	endtask

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic map_model(input mapper_pkg::addr_t a, output mapper_pkg::bank_sel_t sel,
			output mapper_pkg::row_t row, output mapper_pkg::col_t col);
		sel = mapper_pkg::bank_sel_t'(1) << {a[5:4], a[13:12]};
		row = a[29:14];
		col = {a[11:6], a[3:0]};
	endtask

	// lowest free entry of the target table
	task automatic take_tag(input logic write, output mapper_pkg::tag_t tag);
		logic [ENTRIES-1:0] busy;
		busy = write ? wr_model : rd_model;
		tag = '0;
		for (int i = ENTRIES - 1; i >= 0; i--) begin
			if (!busy[i]) tag = mapper_pkg::tag_t'(i);
		end
		if (write) wr_model[tag] = 1'b1;
		else rd_model[tag] = 1'b1;
	endtask

	task automatic retire(input logic write, input mapper_pkg::tag_t tag);
		ret_valid = 1'b1;
		ret_write = write;
		ret_tag = tag;
		step();
		ret_valid = 1'b0;
		if (write) wr_model[tag] = 1'b0;
		else rd_model[tag] = 1'b0;
	endtask

	task automatic send_req(input logic write, input mapper_pkg::addr_t addr,
			input mapper_pkg::data_t data);
		logic taken;
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_data = data;
		taken = 1'b0;
		while (!taken) begin
			taken = req_ready;  // held for the whole cycle
			step();
		end
		req_valid = 1'b0;
	endtask

	task automatic check_dispatch(input logic write, input mapper_pkg::addr_t addr,
			input mapper_pkg::data_t data, input mapper_pkg::tag_t tag);
		mapper_pkg::bank_sel_t sel;
		mapper_pkg::row_t row;
		mapper_pkg::col_t col;
		map_model(addr, sel, row, col);
		check_bit("disp_valid", 1'b1, disp_valid);
		check_bit("disp_write", write, disp_write);
		check_bank_sel("disp_bank_sel", sel, disp_bank_sel);
		check_row("disp_row", row, disp_row);
		check_col("disp_col", col, disp_col);
		if (write) check_data("disp_data", data, disp_data);
		check_tag("disp_tag", tag, disp_tag);
	endtask

	task automatic wait_dispatch(input logic write, input mapper_pkg::addr_t addr,
			input mapper_pkg::data_t data, input mapper_pkg::tag_t tag);
		while (!disp_valid) step();
		check_dispatch(write, addr, data, tag);
		step();
	endtask

	task automatic test_mapping();
		logic [31:0] r;
		mapper_pkg::addr_t addr;
		mapper_pkg::tag_t tag;
		for (int i = 0; i < 34; i++) begin
			if (i < 32) begin
				draw_bits(30, r);
			end
			addr = (i == 32) ? '0 : (i == 33) ? '1 : mapper_pkg::addr_t'(r);
			send_req(1'b0, addr, '0);
			take_tag(1'b0, tag);
			check_bit("disp_valid", 1'b0, disp_valid);  // one edge after accept
			step();
			check_bit("disp_valid", 1'b0, disp_valid);
			step();
			check_dispatch(1'b0, addr, '0, tag);
			retire(1'b0, tag);
		end
	endtask

	task automatic test_tags();
		logic [31:0] a;
		logic [31:0] d;
		mapper_pkg::tag_t tag;
		for (int i = 0; i < ENTRIES; i++) begin
			draw_bits(30, a);
			draw_bits(32, d);
			send_req(1'b1, mapper_pkg::addr_t'(a), d);
			take_tag(1'b1, tag);
			wait_dispatch(1'b1, mapper_pkg::addr_t'(a), d, tag);
		end
		draw_bits(30, a);
		send_req(1'b0, mapper_pkg::addr_t'(a), '0);
		take_tag(1'b0, tag);  // read table is still empty
		wait_dispatch(1'b0, mapper_pkg::addr_t'(a), '0, tag);
		retire(1'b0, tag);
	endtask

	task automatic test_table_full();
		logic [31:0] a;
		logic [31:0] d;
		mapper_pkg::tag_t tag;
		draw_bits(30, a);
		draw_bits(32, d);
		send_req(1'b1, mapper_pkg::addr_t'(a), d);
		for (int i = 0; i < 10; i++) begin
			check_bit("req_ready", 1'b0, req_ready);
			check_bit("disp_valid", 1'b0, disp_valid);
			step();
		end
		retire(1'b1, 6'd5);
		take_tag(1'b1, tag);
		wait_dispatch(1'b1, mapper_pkg::addr_t'(a), d, tag);
		for (int t = 0; t < ENTRIES; t++) begin
			retire(1'b1, mapper_pkg::tag_t'(t));
		end
	endtask

	task automatic test_backpressure();
		logic [31:0] a;
		mapper_pkg::addr_t addrs [4];
		mapper_pkg::tag_t tags [4];
		disp_ready = 1'b0;
		for (int i = 0; i < 4; i++) begin
			draw_bits(30, a);
			addrs[i] = mapper_pkg::addr_t'(a);
			send_req(1'b0, addrs[i], '0);
			take_tag(1'b0, tags[i]);
		end
		// queue, stage 2 and stage 1 all occupied now
		for (int i = 0; i < 4; i++) begin
			check_bit("req_ready", 1'b0, req_ready);
			check_dispatch(1'b0, addrs[0], '0, tags[0]);
			step();
		end
		disp_ready = 1'b1;
		for (int i = 0; i < 4; i++) begin
			wait_dispatch(1'b0, addrs[i], '0, tags[i]);
		end
		for (int i = 0; i < 4; i++) begin
			retire(1'b0, tags[i]);
		end
	endtask

	task automatic test_reset();
		logic [31:0] a;
		mapper_pkg::tag_t tag;
		disp_ready = 1'b0;
		draw_bits(30, a);
		send_req(1'b0, mapper_pkg::addr_t'(a), '0);
		draw_bits(30, a);
		send_req(1'b0, mapper_pkg::addr_t'(a), '0);
		rst = 1'b1;
		step();
		check_bit("req_ready", 1'b0, req_ready);
		step();
		rst = 1'b0;
		rd_model = '0;
		wr_model = '0;
		check_bit("disp_valid", 1'b0, disp_valid);
		disp_ready = 1'b1;
		draw_bits(30, a);
		send_req(1'b0, mapper_pkg::addr_t'(a), '0);
		take_tag(1'b0, tag);
		wait_dispatch(1'b0, mapper_pkg::addr_t'(a), '0, tag);
		retire(1'b0, tag);
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_data = '0;
		disp_ready = 1'b1;
		ret_valid = 1'b0;
		ret_write = 1'b0;
		ret_tag = '0;
		lfsr = 32'he34bc120;
		rd_model = '0;
		wr_model = '0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		test_mapping();
		test_tags();
		test_table_full();
		test_backpressure();
		test_reset();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/mapper_pkg.sv
source/req_if.sv
source/addr_mapper.sv
source/entry_table.sv
source/bank_dispatch.sv
source/mapper_top.sv
bench/mapper_tb.sv

/* Makefile */
# Verilator build for the request front end

VERILATOR ?= verilator
TOP ?= mapper_tb
FILE_LIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing
JOBS ?= 0
PASS_MSG ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILE_LIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
